// ==== ising_core.f ====
rtl/ising_pkg.sv
rtl/ising_l1_mem.sv
rtl/ising_reg_if.sv
rtl/ising_weight_loader.sv
rtl/ising_anneal_ctrl.sv
rtl/ising_spin_array.sv
rtl/ising_core.sv
tests/tb_ising_core.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = tb_ising_core
FILELIST = ising_core.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== tests/tb_ising_core.sv ====
`timescale 1ns/1ps

module tb_ising_core;

    localparam int NUM_SPIN  = ising_pkg::DEF_NUM_SPIN;
    localparam int ROW_W     = NUM_SPIN * ising_pkg::DEF_BIT_J;
    localparam int MAW       = $clog2(NUM_SPIN);
    localparam int DW        = ising_pkg::REG_DATA_W;
    localparam int NUM_CASES = 7;
    // Longest iteration count in the case table
    localparam int MAX_ITER  = 5;
    localparam int TIMEOUT_CYCLES = NUM_CASES * (NUM_SPIN + 3 + 2 * MAX_ITER + 40);
    // Initial spins set up before the ignored idle start
    localparam logic [NUM_SPIN-1:0] IDLE_SPIN = 4'b1001;

    // One annealing job with its weights, run setup and expected outcome
    typedef struct packed {
        logic [0:NUM_SPIN-1][ROW_W-1:0] j_rows;
        logic [ROW_W-1:0]               h_row;
        ising_pkg::mode_e               mode;
        logic [NUM_SPIN-1:0]            spin_init;
        logic [ising_pkg::ITER_W-1:0]   iter;
        logic [NUM_SPIN-1:0]            exp_spin;
        logic                           exp_done;
    } case_t;

    logic             clk_i;
    logic             rst_n_i;
    logic             mem_we_i;
    logic             mem_sel_i;
    logic [MAW-1:0]   mem_addr_i;
    logic [ROW_W-1:0] mem_wdata_i;
    logic             reg_we_i;
    logic [2:0]       reg_addr_i;
    logic [DW-1:0]    reg_wdata_i;
    logic [DW-1:0]    reg_rdata_o;

    int    cycle_cnt = 0;
    case_t cases [NUM_CASES];

    ising_core u_ising_core (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .mem_we_i    (mem_we_i),
        .mem_sel_i   (mem_sel_i),
        .mem_addr_i  (mem_addr_i),
        .mem_wdata_i (mem_wdata_i),
        .reg_we_i    (reg_we_i),
        .reg_addr_i  (reg_addr_i),
        .reg_wdata_i (reg_wdata_i),
        .reg_rdata_o (reg_rdata_o)
    );

    always #4 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the DUT did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test FAILED");
            $fatal(1, "run stopped by cycle limit");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Host access and checking
    //////////////////////////////////////////////////////////////////////
    task automatic check(input string name, input logic [DW-1:0] got, input logic [DW-1:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            $display("Test FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic mem_write(input ising_pkg::mem_sel_e sel, input logic [MAW-1:0] addr,
                             input logic [ROW_W-1:0] data);
        @(posedge clk_i);
        mem_we_i    <= 1'b1;
        mem_sel_i   <= sel;
        mem_addr_i  <= addr;
        mem_wdata_i <= data;
        @(posedge clk_i);
        mem_we_i    <= 1'b0;
    endtask

    task automatic reg_write(input ising_pkg::reg_addr_e addr, input logic [DW-1:0] data);
        @(posedge clk_i);
        reg_we_i    <= 1'b1;
        reg_addr_i  <= addr;
        reg_wdata_i <= data;
        @(posedge clk_i);
        reg_we_i    <= 1'b0;
    endtask

    // Readback is combinational so it is sampled mid cycle
    task automatic reg_read(input ising_pkg::reg_addr_e addr, output logic [DW-1:0] data);
        @(posedge clk_i);
        reg_we_i   <= 1'b0;
        reg_addr_i <= addr;
        @(negedge clk_i);
        data = reg_rdata_o;
    endtask

    task automatic wait_status(input int idx);
        logic [DW-1:0] rd;
        do begin
            reg_read(ising_pkg::REG_STATUS, rd);
        end while (rd[idx] == 1'b0);
    endtask

    // Status bit 0 is load_done, bit 1 busy and bit 2 done
    function automatic logic [DW-1:0] status_word(input logic done, input logic busy,
                                                  input logic load_done);
        logic [DW-1:0] w;
        w    = '0;
        w[0] = load_done;
        w[1] = busy;
        w[2] = done;
        return w;
    endfunction

    task automatic load_weights(input case_t c);
        for (int r = 0; r < NUM_SPIN; r++) begin
            mem_write(ising_pkg::MEM_J, MAW'(r), c.j_rows[r]);
        end
        mem_write(ising_pkg::MEM_H, '0, c.h_row);
        reg_write(ising_pkg::REG_MODE, DW'(ising_pkg::MODE_LOAD));
        wait_status(0);
    endtask

    task automatic run_job(input case_t c);
        reg_write(ising_pkg::REG_SPIN_INIT, DW'(c.spin_init));
        reg_write(ising_pkg::REG_ITER, DW'(c.iter));
        reg_write(ising_pkg::REG_MODE, DW'(c.mode));
        reg_write(ising_pkg::REG_START, DW'(1));
        wait_status(2);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Case table
    //////////////////////////////////////////////////////////////////////
    // Spin bit i set means +1 and nibble j of row i holds J_ij
    task automatic build_table();
        // All-zero J so the fields equal h and h0 = h3 = 0 hit the tie
        cases[0] = '{j_rows: {16'h0000, 16'h0000, 16'h0000, 16'h0000}, h_row: 16'h0F10,
                     mode: ising_pkg::MODE_COMPUTE, spin_init: 4'b0000, iter: 8'd1,
                     exp_spin: 4'b1011, exp_done: 1'b1};
        // Ferromagnetic with a large diagonal that oscillates 0011 <-> 1100
        cases[1] = '{j_rows: {16'h1117, 16'h1171, 16'h1711, 16'h7111}, h_row: 16'h0000,
                     mode: ising_pkg::MODE_COMPUTE, spin_init: 4'b0011, iter: 8'd3,
                     exp_spin: 4'b1100, exp_done: 1'b1};
        cases[2] = '{j_rows: {16'h1117, 16'h1171, 16'h1711, 16'h7111}, h_row: 16'h0000,
                     mode: ising_pkg::MODE_DEBUG, spin_init: 4'b0011, iter: 8'd3,
                     exp_spin: 4'b1100, exp_done: 1'b1};
        // Settles on all up
        cases[3] = '{j_rows: {16'h1117, 16'h1171, 16'h1711, 16'h7111}, h_row: 16'h0000,
                     mode: ising_pkg::MODE_COMPUTE, spin_init: 4'b0111, iter: 8'd5,
                     exp_spin: 4'b1111, exp_done: 1'b1};
        cases[4] = '{j_rows: {16'h1117, 16'h1171, 16'h1711, 16'h7111}, h_row: 16'h0000,
                     mode: ising_pkg::MODE_COMPUTE, spin_init: 4'b0101, iter: 8'd0,
                     exp_spin: 4'b0101, exp_done: 1'b1};
        // Antiferromagnetic reload where 0011 is a fixed point
        cases[5] = '{j_rows: {16'hFFF0, 16'hFF0F, 16'hF0FF, 16'h0FFF}, h_row: 16'h0000,
                     mode: ising_pkg::MODE_COMPUTE, spin_init: 4'b0011, iter: 8'd2,
                     exp_spin: 4'b0011, exp_done: 1'b1};
        // Mixed signs with -8 and 7
        // Fields -15 -2 1 5 in the first sweep and 15 -6 3 -21 in the second
        cases[6] = '{j_rows: {16'h0780, 16'hEE03, 16'hF0FF, 16'h0855}, h_row: 16'hD210,
                     mode: ising_pkg::MODE_COMPUTE, spin_init: 4'b1010, iter: 8'd2,
                     exp_spin: 4'b0101, exp_done: 1'b1};
    endtask

    initial begin
        case_t               c;
        logic [DW-1:0]       rd;
        logic [NUM_SPIN-1:0] prev_result;
        logic                prev_done;
        clk_i       = 1'b0;
        rst_n_i     = 1'b0;
        mem_we_i    = 1'b0;
        mem_sel_i   = 1'b0;
        mem_addr_i  = '0;
        mem_wdata_i = '0;
        reg_we_i    = 1'b0;
        reg_addr_i  = '0;
        reg_wdata_i = '0;
        prev_result = '0;
        prev_done   = 1'b0;
        build_table();
        repeat (3) @(posedge clk_i);
        rst_n_i <= 1'b1;

        reg_read(ising_pkg::REG_MODE, rd);
        check("REG_MODE after reset", rd, '0);
        reg_read(ising_pkg::REG_STATUS, rd);
        check("REG_STATUS after reset", rd, '0);
        reg_read(ising_pkg::REG_RESULT, rd);
        check("REG_RESULT after reset", rd, '0);

        // Start in idle mode must be ignored
        // A zero-iteration job would put IDLE_SPIN into REG_RESULT
        reg_write(ising_pkg::REG_SPIN_INIT, DW'(IDLE_SPIN));
        reg_write(ising_pkg::REG_ITER, DW'(0));
        reg_write(ising_pkg::REG_START, DW'(1));
        reg_read(ising_pkg::REG_STATUS, rd);
        check("REG_STATUS after idle start", rd, '0);
        reg_read(ising_pkg::REG_SPIN_INIT, rd);
        check("REG_SPIN_INIT readback", rd, DW'(IDLE_SPIN));
        reg_read(ising_pkg::REG_RESULT, rd);
        check("REG_RESULT after idle start", rd, '0);

        for (int n = 0; n < NUM_CASES; n++) begin
            c = cases[n];
            load_weights(c);
            // Same for a start in load mode
            reg_write(ising_pkg::REG_START, DW'(1));
            reg_read(ising_pkg::REG_STATUS, rd);
            check($sformatf("REG_STATUS case %0d load start", n), rd,
                  status_word(prev_done, 1'b0, 1'b1));
            reg_write(ising_pkg::REG_MODE, DW'(ising_pkg::MODE_IDLE));
            reg_read(ising_pkg::REG_STATUS, rd);
            check($sformatf("REG_STATUS case %0d back to idle", n), rd,
                  status_word(prev_done, 1'b0, 1'b0));
            reg_read(ising_pkg::REG_RESULT, rd);
            check($sformatf("REG_RESULT case %0d load start", n), rd, DW'(prev_result));

            run_job(c);
            reg_read(ising_pkg::REG_RESULT, rd);
            check($sformatf("REG_RESULT case %0d", n), rd, DW'(c.exp_spin));
            reg_read(ising_pkg::REG_STATUS, rd);
            check($sformatf("REG_STATUS case %0d", n), rd, status_word(c.exp_done, 1'b0, 1'b0));
            prev_result = c.exp_spin;
            prev_done   = c.exp_done;
        end

        $display("Test OK");
        $finish;
    end

endmodule

// ==== rtl/ising_core.sv ====
`timescale 1ns/1ps

module ising_core #(
    parameter int  NUM_SPIN = ising_pkg::DEF_NUM_SPIN,
    parameter int  BIT_J    = ising_pkg::DEF_BIT_J,
    parameter int  BIT_H    = ising_pkg::DEF_BIT_H,
    localparam int ROW_W    = NUM_SPIN * BIT_J,
    localparam int MAW      = $clog2(NUM_SPIN)
) (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             mem_we_i,
    input  logic                             mem_sel_i,
    input  logic [MAW-1:0]                   mem_addr_i,
    input  logic [ROW_W-1:0]                 mem_wdata_i,
    input  logic                             reg_we_i,
    input  logic [2:0]                       reg_addr_i,
    input  logic [ising_pkg::REG_DATA_W-1:0] reg_wdata_i,
    output logic [ising_pkg::REG_DATA_W-1:0] reg_rdata_o
);

    localparam int AW = $clog2(NUM_SPIN + 1);

    ising_pkg::mode_e             mode;
    logic [NUM_SPIN-1:0]          spin_init;
    logic [ising_pkg::ITER_W-1:0] iter;
    logic                         start;
    logic                         load_done;
    logic                         busy;
    logic                         done;
    logic [NUM_SPIN-1:0]          result;
    logic                         result_we;
    logic                         j_we;
    logic                         h_we;
    logic                         rd_en;
    logic [AW-1:0]                rd_addr;
    logic [ROW_W-1:0]             j_rd_data;
    logic [ROW_W-1:0]             h_rd_data;
    logic                         w_en;
    logic [AW-1:0]                w_addr;
    logic [ROW_W-1:0]             w_data;
    logic                         spin_wen;
    logic [NUM_SPIN-1:0]          wr_spin;
    logic                         compute_en;
    logic                         spin_vld;
    logic                         spin_rdy;
    logic [NUM_SPIN-1:0]          spin;

    //////////////////////////////////////////////////////////////////////
    // Host-written coupling and bias memories
    //////////////////////////////////////////////////////////////////////
    assign j_we = mem_we_i && (mem_sel_i == ising_pkg::MEM_J);
    assign h_we = mem_we_i && (mem_sel_i == ising_pkg::MEM_H);

    ising_l1_mem #(.DEPTH(NUM_SPIN), .WIDTH(ROW_W)) j_mem (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .we_i      (j_we),
        .waddr_i   (mem_addr_i),
        .wdata_i   (mem_wdata_i),
        .rd_en_i   (rd_en),
        .rd_addr_i (rd_addr[MAW-1:0]),
        .rd_data_o (j_rd_data)
    );

    // Single h row
    ising_l1_mem #(.DEPTH(1), .WIDTH(ROW_W)) h_mem (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .we_i      (h_we),
        .waddr_i   (1'b0),
        .wdata_i   (mem_wdata_i),
        .rd_en_i   (rd_en),
        .rd_addr_i (1'b0),
        .rd_data_o (h_rd_data)
    );

    //////////////////////////////////////////////////////////////////////
    // Registers, loader, controller and spin array
    //////////////////////////////////////////////////////////////////////
    ising_reg_if #(.NUM_SPIN(NUM_SPIN)) u_reg_if (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .reg_we_i    (reg_we_i),
        .reg_addr_i  (reg_addr_i),
        .reg_wdata_i (reg_wdata_i),
        .load_done_i (load_done),
        .busy_i      (busy),
        .done_i      (done),
        .result_i    (result),
        .result_we_i (result_we),
        .reg_rdata_o (reg_rdata_o),
        .mode_o      (mode),
        .spin_init_o (spin_init),
        .iter_o      (iter),
        .start_o     (start)
    );

    ising_weight_loader #(.NUM_SPIN(NUM_SPIN), .BIT_J(BIT_J), .BIT_H(BIT_H)) u_loader (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .mode_i      (mode),
        .j_rd_data_i (j_rd_data),
        .h_rd_data_i (h_rd_data),
        .rd_en_o     (rd_en),
        .rd_addr_o   (rd_addr),
        .w_en_o      (w_en),
        .w_addr_o    (w_addr),
        .w_data_o    (w_data),
        .load_done_o (load_done)
    );

    ising_anneal_ctrl #(.NUM_SPIN(NUM_SPIN)) u_anneal_ctrl (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .mode_i       (mode),
        .start_i      (start),
        .spin_init_i  (spin_init),
        .iter_i       (iter),
        .spin_vld_i   (spin_vld),
        .spin_i       (spin),
        .spin_wen_o   (spin_wen),
        .wr_spin_o    (wr_spin),
        .compute_en_o (compute_en),
        .spin_rdy_o   (spin_rdy),
        .busy_o       (busy),
        .done_o       (done),
        .result_o     (result),
        .result_we_o  (result_we)
    );

    ising_spin_array #(.NUM_SPIN(NUM_SPIN), .BIT_J(BIT_J), .BIT_H(BIT_H)) u_spin_array (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .w_en_i       (w_en),
        .w_addr_i     (w_addr),
        .w_data_i     (w_data),
        .spin_wen_i   (spin_wen),
        .wr_spin_i    (wr_spin),
        .compute_en_i (compute_en),
        .spin_rdy_i   (spin_rdy),
        .spin_vld_o   (spin_vld),
        .spin_o       (spin)
    );

endmodule

// ==== rtl/ising_spin_array.sv ====
`timescale 1ns/1ps

module ising_spin_array #(
    parameter int  NUM_SPIN = 4,
    parameter int  BIT_J    = 4,
    parameter int  BIT_H    = 4,
    localparam int ROW_W    = NUM_SPIN * BIT_J,
    localparam int AW       = $clog2(NUM_SPIN + 1)
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                w_en_i,
    input  logic [AW-1:0]       w_addr_i,
    input  logic [ROW_W-1:0]    w_data_i,
    input  logic                spin_wen_i,
    input  logic [NUM_SPIN-1:0] wr_spin_i,
    input  logic                compute_en_i,
    input  logic                spin_rdy_i,
    output logic                spin_vld_o,
    output logic [NUM_SPIN-1:0] spin_o
);

    localparam int H_W = NUM_SPIN * BIT_H;
    // Room for h plus NUM_SPIN-1 signed terms
    localparam int FW  = ((BIT_J > BIT_H) ? BIT_J : BIT_H) + $clog2(NUM_SPIN) + 2;

    logic [ROW_W-1:0]    j_q [NUM_SPIN];
    logic [H_W-1:0]      h_q;
    logic [NUM_SPIN-1:0] next_spin;

    //////////////////////////////////////////////////////////////////////
    // Local field evaluation
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        logic signed [FW-1:0] acc;
        logic signed [FW-1:0] term;
        for (int i = 0; i < NUM_SPIN; i++) begin
            acc = FW'(signed'(h_q[i*BIT_H +: BIT_H]));
            for (int j = 0; j < NUM_SPIN; j++) begin
                term = FW'(signed'(j_q[i][j*BIT_J +: BIT_J]));
                // Diagonal does not couple a spin to itself
                if (j != i) begin
                    acc = spin_o[j] ? acc + term : acc - term;
                end
            end
            // Zero field counts as +1
            next_spin[i] = ~acc[FW-1];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Weight, spin and handshake registers
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            j_q        <= '{default: '0};
            h_q        <= '0;
            spin_o     <= '0;
            spin_vld_o <= 1'b0;
        end else begin
            if (w_en_i) begin
                for (int r = 0; r < NUM_SPIN; r++) begin
                    if (w_addr_i == AW'(r)) j_q[r] <= w_data_i;
                end
                if (w_addr_i == AW'(NUM_SPIN)) h_q <= w_data_i[H_W-1:0];
            end
            if (spin_wen_i) begin
                spin_o <= wr_spin_i;
            end else if (compute_en_i) begin
                spin_o <= next_spin;
            end
            // Result stays valid until the controller takes it
            if (compute_en_i) begin
                spin_vld_o <= 1'b1;
            end else if (spin_rdy_i) begin
                spin_vld_o <= 1'b0;
            end
        end
    end

endmodule

// ==== rtl/ising_anneal_ctrl.sv ====
`timescale 1ns/1ps

module ising_anneal_ctrl #(
    parameter int NUM_SPIN = 4
) (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  ising_pkg::mode_e              mode_i,
    input  logic                          start_i,
    input  logic [NUM_SPIN-1:0]           spin_init_i,
    input  logic [ising_pkg::ITER_W-1:0]  iter_i,
    input  logic                          spin_vld_i,
    input  logic [NUM_SPIN-1:0]           spin_i,
    output logic                          spin_wen_o,
    output logic [NUM_SPIN-1:0]           wr_spin_o,
    output logic                          compute_en_o,
    output logic                          spin_rdy_o,
    output logic                          busy_o,
    output logic                          done_o,
    output logic [NUM_SPIN-1:0]           result_o,
    output logic                          result_we_o
);

    typedef enum logic [2:0] {
        AN_IDLE,
        AN_WRITE,
        AN_SWEEP,
        AN_WAIT,
        AN_DONE
    } an_state_e;

    an_state_e                    state_q;
    logic [ising_pkg::ITER_W-1:0] cnt_q;
    logic [NUM_SPIN-1:0]          init_q;
    logic                         run_mode;
    logic                         start_ok;
    logic                         cnt_zero;

    assign run_mode = (mode_i == ising_pkg::MODE_COMPUTE) || (mode_i == ising_pkg::MODE_DEBUG);
    assign start_ok = start_i && run_mode && !busy_o;
    assign cnt_zero = (cnt_q == '0);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= AN_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                AN_IDLE, AN_DONE: begin
                    if (start_ok) begin
                        state_q <= AN_WRITE;
                        cnt_q   <= iter_i;
                    end
                end
                AN_WRITE: state_q <= AN_SWEEP;
                AN_SWEEP: begin
                    if (cnt_zero) begin
                        state_q <= AN_DONE;
                    end else begin
                        cnt_q   <= cnt_q - 1'b1;
                        state_q <= AN_WAIT;
                    end
                end
                AN_WAIT: if (spin_vld_i) state_q <= AN_SWEEP;
                default: state_q <= AN_IDLE;
            endcase
        end
    end

    // Snapshot of the initial spins for this job
    always_ff @(posedge clk_i) begin
        if (start_ok) begin
            init_q <= spin_init_i;
        end
    end

    assign spin_wen_o   = (state_q == AN_WRITE);
    assign wr_spin_o    = init_q;
    assign compute_en_o = (state_q == AN_SWEEP) && !cnt_zero;
    assign spin_rdy_o   = (state_q == AN_WAIT);
    // Array already holds the final vector when the count runs out
    assign result_we_o  = (state_q == AN_SWEEP) && cnt_zero;
    assign result_o     = spin_i;
    assign busy_o       = (state_q == AN_WRITE) || (state_q == AN_SWEEP) || (state_q == AN_WAIT);
    assign done_o       = (state_q == AN_DONE);

endmodule

// ==== rtl/ising_weight_loader.sv ====
`timescale 1ns/1ps

module ising_weight_loader #(
    parameter int  NUM_SPIN = 4,
    parameter int  BIT_J    = 4,
    parameter int  BIT_H    = 4,
    localparam int ROW_W    = NUM_SPIN * BIT_J,
    localparam int AW       = $clog2(NUM_SPIN + 1)
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  ising_pkg::mode_e    mode_i,
    input  logic [ROW_W-1:0]    j_rd_data_i,
    input  logic [ROW_W-1:0]    h_rd_data_i,
    output logic                rd_en_o,
    output logic [AW-1:0]       rd_addr_o,
    output logic                w_en_o,
    output logic [AW-1:0]       w_addr_o,
    output logic [ROW_W-1:0]    w_data_o,
    output logic                load_done_o
);

    localparam int H_W = NUM_SPIN * BIT_H;

    typedef enum logic [1:0] {
        LD_IDLE,
        LD_READ,
        LD_DONE
    } ld_state_e;

    ld_state_e     state_q;
    logic [AW-1:0] cnt_q;
    logic          last_rd;

    assign rd_en_o   = (state_q == LD_READ);
    assign rd_addr_o = cnt_q;
    assign last_rd   = (cnt_q == AW'(NUM_SPIN));

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= LD_IDLE;
            cnt_q       <= '0;
            w_en_o      <= 1'b0;
            w_addr_o    <= '0;
            load_done_o <= 1'b0;
        end else begin
            // Array write trails its memory read by one cycle
            w_en_o   <= rd_en_o;
            w_addr_o <= cnt_q;
            if (mode_i != ising_pkg::MODE_LOAD) begin
                load_done_o <= 1'b0;
            end else if (w_en_o && w_addr_o == AW'(NUM_SPIN)) begin
                load_done_o <= 1'b1;
            end
            case (state_q)
                LD_IDLE: if (mode_i == ising_pkg::MODE_LOAD) state_q <= LD_READ;
                LD_READ: begin
                    cnt_q <= last_rd ? '0 : cnt_q + 1'b1;
                    if (last_rd) state_q <= LD_DONE;
                end
                // Rearm only once the host has left load mode
                LD_DONE: if (mode_i != ising_pkg::MODE_LOAD) state_q <= LD_IDLE;
                default: state_q <= LD_IDLE;
            endcase
        end
    end

    // Last address is the h row zero extended to row width
    assign w_data_o = (w_addr_o == AW'(NUM_SPIN)) ? ROW_W'(h_rd_data_i[H_W-1:0]) : j_rd_data_i;

endmodule

// ==== rtl/ising_reg_if.sv ====
`timescale 1ns/1ps

module ising_reg_if #(
    parameter int NUM_SPIN = 4
) (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  logic                              reg_we_i,
    input  logic [2:0]                        reg_addr_i,
    input  logic [ising_pkg::REG_DATA_W-1:0]  reg_wdata_i,
    input  logic                              load_done_i,
    input  logic                              busy_i,
    input  logic                              done_i,
    input  logic [NUM_SPIN-1:0]               result_i,
    input  logic                              result_we_i,
    output logic [ising_pkg::REG_DATA_W-1:0]  reg_rdata_o,
    output ising_pkg::mode_e                  mode_o,
    output logic [NUM_SPIN-1:0]               spin_init_o,
    output logic [ising_pkg::ITER_W-1:0]      iter_o,
    output logic                              start_o
);

    localparam int DW = ising_pkg::REG_DATA_W;

    logic [NUM_SPIN-1:0] result_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mode_o      <= ising_pkg::MODE_IDLE;
            spin_init_o <= '0;
            iter_o      <= '0;
            start_o     <= 1'b0;
            result_q    <= '0;
        end else begin
            // Start is a single-cycle strobe
            start_o <= 1'b0;
            if (result_we_i) begin
                result_q <= result_i;
            end
            if (reg_we_i) begin
                case (ising_pkg::reg_addr_e'(reg_addr_i))
                    ising_pkg::REG_MODE:      mode_o <= ising_pkg::mode_e'(reg_wdata_i[1:0]);
                    ising_pkg::REG_SPIN_INIT: spin_init_o <= reg_wdata_i[NUM_SPIN-1:0];
                    ising_pkg::REG_ITER:      iter_o <= reg_wdata_i[ising_pkg::ITER_W-1:0];
                    ising_pkg::REG_START:     start_o <= reg_wdata_i[0];
                    default: ;
                endcase
            end
        end
    end

    // Combinational readback
    always_comb begin
        case (ising_pkg::reg_addr_e'(reg_addr_i))
            ising_pkg::REG_MODE:      reg_rdata_o = DW'(mode_o);
            ising_pkg::REG_SPIN_INIT: reg_rdata_o = DW'(spin_init_o);
            ising_pkg::REG_ITER:      reg_rdata_o = DW'(iter_o);
            ising_pkg::REG_STATUS:    reg_rdata_o = DW'({done_i, busy_i, load_done_i});
            ising_pkg::REG_RESULT:    reg_rdata_o = DW'(result_q);
            default:                  reg_rdata_o = '0;
        endcase
    end

endmodule

// ==== rtl/ising_l1_mem.sv ====
`timescale 1ns/1ps

module ising_l1_mem #(
    parameter int  DEPTH = 4,
    parameter int  WIDTH = 16,
    localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             we_i,
    input  logic [AW-1:0]    waddr_i,
    input  logic [WIDTH-1:0] wdata_i,
    input  logic             rd_en_i,
    input  logic [AW-1:0]    rd_addr_i,
    output logic [WIDTH-1:0] rd_data_o
);

    logic [WIDTH-1:0] rows [DEPTH];

    // Rows start at zero so an unloaded array sees zero weights
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rows      <= '{default: '0};
            rd_data_o <= '0;
        end else begin
            for (int r = 0; r < DEPTH; r++) begin
                if (we_i && waddr_i == AW'(r)) begin
                    rows[r] <= wdata_i;
                end
            end
            // Registered read with data valid the cycle after rd_en
            if (rd_en_i) begin
                for (int r = 0; r < DEPTH; r++) begin
                    if (rd_addr_i == AW'(r)) begin
                        rd_data_o <= rows[r];
                    end
                end
            end
        end
    end

endmodule

// ==== rtl/ising_pkg.sv ====
package ising_pkg;

    // Operating mode where debug runs like compute
    typedef enum logic [1:0] {
        MODE_IDLE    = 2'd0,
        MODE_LOAD    = 2'd1,
        MODE_COMPUTE = 2'd2,
        MODE_DEBUG   = 2'd3
    } mode_e;

    // Host register map
    typedef enum logic [2:0] {
        REG_MODE      = 3'd0,
        REG_SPIN_INIT = 3'd1,
        REG_ITER      = 3'd2,
        REG_START     = 3'd3,
        REG_STATUS    = 3'd4,
        REG_RESULT    = 3'd5
    } reg_addr_e;

    // Host memory target
    typedef enum logic {
        MEM_J = 1'b0,
        MEM_H = 1'b1
    } mem_sel_e;

    localparam int DEF_NUM_SPIN = 4;
    localparam int DEF_BIT_J    = 4;
    localparam int DEF_BIT_H    = 4;

    localparam int REG_DATA_W   = 16;
    localparam int ITER_W       = 8;

endpackage
